//--- cabinet_settings.svh
`ifndef CABINET_SETTINGS_SVH
`define CABINET_SETTINGS_SVH

// Width of each VGA color channel
`define CAB_VGA_BITS 6

// Width of the audio sample fed to the sigma-delta DAC
`define CAB_DAC_BITS 8

// Overlay bands, counted in rows from the top of the frame
`define CAB_SCORE_ROW_END 32   // First row below the red score band
`define CAB_BASE_ROW_START 184 // First row of the green base band

`endif

//--- cab_input_pkg.sv
`default_nettype none

package cab_input_pkg;

	// Host controller scancodes that map to cabinet buttons
	typedef enum logic [7:0] {
		KEY_START_1P = 8'h05, // F1
		KEY_START_2P = 8'h06, // F2
		KEY_FIRE     = 8'h29, // Space
		KEY_LEFT     = 8'h6B,
		KEY_RIGHT    = 8'h74,
		KEY_COIN     = 8'h76  // Escape
	} key_scancode_t;

	// Bit positions inside a joystick byte, the other bits are not wired
	typedef enum logic [2:0] {
		JOY_RIGHT = 3'd0,
		JOY_LEFT  = 3'd1,
		JOY_FIRE  = 3'd4
	} cab_joy_bit_t;

endpackage

`default_nettype wire

//--- cab_video_pkg.sv
`default_nettype none

package cab_video_pkg;

	// Strength of the dimming applied to odd lines
	typedef enum logic [1:0] {
		SCAN_OFF = 2'd0,
		SCAN_25  = 2'd1,
		SCAN_50  = 2'd2,
		SCAN_75  = 2'd3
	} scanline_level_t;

	// Overlay colors as an {r, g, b} bit triple
	typedef enum logic [2:0] {
		COLOR_BLACK = 3'b000,
		COLOR_GREEN = 3'b010,
		COLOR_RED   = 3'b100,
		COLOR_WHITE = 3'b111
	} overlay_color_t;

endpackage

`default_nettype wire

//--- key_decoder.sv
`default_nettype none

module key_decoder
	import cab_input_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       key_strobe,
	input  logic       key_pressed,
	input  logic [7:0] key_code,
	input  logic [7:0] joystick_0,
	input  logic [7:0] joystick_1,
	output logic       move_left,
	output logic       move_right,
	output logic       fire,
	output logic       coin,
	output logic       start_1p,
	output logic       start_2p
);

	logic key_left;
	logic key_right;
	logic key_fire;
	logic key_coin;
	logic key_start_1p;
	logic key_start_2p;

	logic nxt_left;
	logic nxt_right;
	logic nxt_fire;
	logic nxt_coin;
	logic nxt_start_1p;
	logic nxt_start_2p;

	// Next held levels, so a strobe reaches the outputs in one cycle
	always_comb begin
		nxt_left     = key_left;
		nxt_right    = key_right;
		nxt_fire     = key_fire;
		nxt_coin     = key_coin;
		nxt_start_1p = key_start_1p;
		nxt_start_2p = key_start_2p;
		if (key_strobe) begin
			case (key_code)
				KEY_LEFT:     nxt_left     = key_pressed;
				KEY_RIGHT:    nxt_right    = key_pressed;
				KEY_FIRE:     nxt_fire     = key_pressed;
				KEY_COIN:     nxt_coin     = key_pressed;
				KEY_START_1P: nxt_start_1p = key_pressed;
				KEY_START_2P: nxt_start_2p = key_pressed;
				default:      ; // Unknown codes leave every key alone
			endcase
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			key_left     <= 1'b0;
			key_right    <= 1'b0;
			key_fire     <= 1'b0;
			key_coin     <= 1'b0;
			key_start_1p <= 1'b0;
			key_start_2p <= 1'b0;
			move_left    <= 1'b0;
			move_right   <= 1'b0;
			fire         <= 1'b0;
			coin         <= 1'b0;
			start_1p     <= 1'b0;
			start_2p     <= 1'b0;
		end else begin
			key_left     <= nxt_left;
			key_right    <= nxt_right;
			key_fire     <= nxt_fire;
			key_coin     <= nxt_coin;
			key_start_1p <= nxt_start_1p;
			key_start_2p <= nxt_start_2p;
			move_left    <= nxt_left | joystick_0[JOY_LEFT] | joystick_1[JOY_LEFT];
			move_right   <= nxt_right | joystick_0[JOY_RIGHT] | joystick_1[JOY_RIGHT];
			fire         <= nxt_fire | joystick_0[JOY_FIRE] | joystick_1[JOY_FIRE];
			coin         <= nxt_coin; // Keyboard only
			start_1p     <= nxt_start_1p;
			start_2p     <= nxt_start_2p;
		end
	end

	// One key event carries one code, so both starts cannot rise together
	a_start_exclusive: assert property (@(posedge clk_sys) disable iff (!rst_n)
		key_strobe |=> !($rose(start_1p) && $rose(start_2p)));

endmodule

`default_nettype wire

//--- overlay_colorizer.sv
`default_nettype none

`include "cabinet_settings.svh"

module overlay_colorizer
	import cab_video_pkg::*;
(
	input  logic clk_sys,
	input  logic rst_n,
	input  logic video,
	input  logic hsync,
	input  logic vsync,
	input  logic overlay_off,
	output logic r,
	output logic g,
	output logic b,
	output logic hs,
	output logic vs
);

	localparam int ROW_BITS = 9;

	logic                hsync_d;
	logic                vsync_d;
	logic                hsync_rise;
	logic                vsync_rise;
	logic [ROW_BITS-1:0] row_cnt;
	overlay_color_t      band_color;
	overlay_color_t      pix_color;

	assign hsync_rise = hsync & ~hsync_d;
	assign vsync_rise = vsync & ~vsync_d;

	// Row counter, the vertical sync wins when both edges meet
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			hsync_d <= 1'b0;
			vsync_d <= 1'b0;
			row_cnt <= '0;
		end else begin
			hsync_d <= hsync;
			vsync_d <= vsync;
			if (vsync_rise) begin
				row_cnt <= '0;
			end else if (hsync_rise) begin
				row_cnt <= row_cnt + 1'b1;
			end
		end
	end

	// The cellophane strips cover the score area and the base area
	always_comb begin
		if (overlay_off) begin
			band_color = COLOR_WHITE;
		end else if (row_cnt < `CAB_SCORE_ROW_END) begin
			band_color = COLOR_RED;
		end else if (row_cnt >= `CAB_BASE_ROW_START) begin
			band_color = COLOR_GREEN;
		end else begin
			band_color = COLOR_WHITE;
		end
		pix_color = video ? band_color : COLOR_BLACK;
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			r  <= 1'b0;
			g  <= 1'b0;
			b  <= 1'b0;
			hs <= 1'b0;
			vs <= 1'b0;
		end else begin
			r  <= pix_color[2];
			g  <= pix_color[1];
			b  <= pix_color[0];
			hs <= hsync; // Syncs keep step with the pixel
			vs <= vsync;
		end
	end

	// An unlit pixel stays black whatever band it falls in
	a_dark_pixel: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!video |=> !(r || g || b));

endmodule

`default_nettype wire

//--- scanline_dimmer.sv
`default_nettype none

`include "cabinet_settings.svh"

module scanline_dimmer
	import cab_video_pkg::*;
(
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic                     r,
	input  logic                     g,
	input  logic                     b,
	input  logic                     hs,
	input  logic                     vs,
	input  scanline_level_t          scanlines,
	output logic [`CAB_VGA_BITS-1:0] vga_r,
	output logic [`CAB_VGA_BITS-1:0] vga_g,
	output logic [`CAB_VGA_BITS-1:0] vga_b,
	output logic                     vga_hs,
	output logic                     vga_vs
);

	localparam logic [`CAB_VGA_BITS-1:0] LVL_FULL = '1;
	localparam logic [`CAB_VGA_BITS-1:0] LVL_25   = LVL_FULL - (LVL_FULL >> 2); // 48 at 6 bits
	localparam logic [`CAB_VGA_BITS-1:0] LVL_50   = (LVL_FULL >> 1) + 1'b1;
	localparam logic [`CAB_VGA_BITS-1:0] LVL_75   = (LVL_FULL >> 2) + 1'b1;

	logic                     hs_d;
	logic                     vs_d;
	logic                     line_odd;
	logic [`CAB_VGA_BITS-1:0] lit_level;

	// Line parity follows the syncs as they leave the colorizer
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			hs_d     <= 1'b0;
			vs_d     <= 1'b0;
			line_odd <= 1'b0;
		end else begin
			hs_d <= hs;
			vs_d <= vs;
			if (vs && !vs_d) begin
				line_odd <= 1'b0;
			end else if (hs && !hs_d) begin
				line_odd <= ~line_odd;
			end
		end
	end

	always_comb begin
		lit_level = LVL_FULL;
		if (line_odd) begin
			case (scanlines)
				SCAN_25: lit_level = LVL_25;
				SCAN_50: lit_level = LVL_50;
				SCAN_75: lit_level = LVL_75;
				default: lit_level = LVL_FULL;
			endcase
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else begin
			vga_r  <= r ? lit_level : '0;
			vga_g  <= g ? lit_level : '0;
			vga_b  <= b ? lit_level : '0;
			vga_hs <= hs;
			vga_vs <= vs;
		end
	end

	// Dimming never lights a channel whose color bit was clear
	a_channel_source: assert property (@(posedge clk_sys) disable iff (!rst_n)
		((vga_r != '0) |-> $past(r)) and ((vga_g != '0) |-> $past(g))
		and ((vga_b != '0) |-> $past(b)));

endmodule

`default_nettype wire

//--- sigma_delta_dac.sv
`default_nettype none

`include "cabinet_settings.svh"

module sigma_delta_dac (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic [`CAB_DAC_BITS-1:0] sample,
	output logic                     dac_out
);

	logic [`CAB_DAC_BITS-1:0] acc;
	logic [`CAB_DAC_BITS-1:0] acc_sum;
	logic                     acc_carry;

	// The carry out is the one-bit density of the sample
	assign {acc_carry, acc_sum} = {1'b0, acc} + {1'b0, sample};

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			acc     <= '0;
			dac_out <= 1'b0;
		end else begin
			acc     <= acc_sum;
			dac_out <= acc_carry;
		end
	end

	// The pin drives an external RC filter, an X there is a real fault
	a_dac_known: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!$isunknown(dac_out));

endmodule

`default_nettype wire

//--- cabinet_top.sv
`default_nettype none

`include "cabinet_settings.svh"

module cabinet_top
	import cab_video_pkg::*;
(
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic                     key_strobe,
	input  logic                     key_pressed,
	input  logic [7:0]               key_code,
	input  logic [7:0]               joystick_0,
	input  logic [7:0]               joystick_1,
	input  logic                     video,
	input  logic                     hsync,
	input  logic                     vsync,
	input  logic                     overlay_off,
	input  scanline_level_t          scanlines,
	input  logic [`CAB_DAC_BITS-1:0] audio,
	output logic                     move_left,
	output logic                     move_right,
	output logic                     fire,
	output logic                     coin,
	output logic                     start_1p,
	output logic                     start_2p,
	output logic [`CAB_VGA_BITS-1:0] vga_r,
	output logic [`CAB_VGA_BITS-1:0] vga_g,
	output logic [`CAB_VGA_BITS-1:0] vga_b,
	output logic                     vga_hs,
	output logic                     vga_vs,
	output logic                     audio_out
);

	logic col_r;
	logic col_g;
	logic col_b;
	logic col_hs;
	logic col_vs;

	key_decoder key_decoder_i (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.move_left   (move_left),
		.move_right  (move_right),
		.fire        (fire),
		.coin        (coin),
		.start_1p    (start_1p),
		.start_2p    (start_2p)
	);

	overlay_colorizer overlay_colorizer_i (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.video       (video),
		.hsync       (hsync),
		.vsync       (vsync),
		.overlay_off (overlay_off),
		.r           (col_r),
		.g           (col_g),
		.b           (col_b),
		.hs          (col_hs),
		.vs          (col_vs)
	);

	scanline_dimmer scanline_dimmer_i (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.r         (col_r),
		.g         (col_g),
		.b         (col_b),
		.hs        (col_hs),
		.vs        (col_vs),
		.scanlines (scanlines),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b),
		.vga_hs    (vga_hs),
		.vga_vs    (vga_vs)
	);

	sigma_delta_dac sigma_delta_dac_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.sample  (audio),
		.dac_out (audio_out)
	);

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
	output logic clk_sys,
	output logic rst_n
);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys; // Period of 8
	end

	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk_sys);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

//--- cabinet_tb.sv
`default_nettype none

`include "cabinet_settings.svh"

module cabinet_tb
	import cab_input_pkg::*;
	import cab_video_pkg::*;
;

	logic clk_sys, rst_n;
	logic key_strobe, key_pressed, video, hsync, vsync, overlay_off;
	logic [7:0] key_code, joystick_0, joystick_1;
	logic [`CAB_DAC_BITS-1:0] audio;
	scanline_level_t scanlines;
	logic move_left, move_right, fire, coin, start_1p, start_2p;
	logic [`CAB_VGA_BITS-1:0] vga_r, vga_g, vga_b;
	logic vga_hs, vga_vs, audio_out;

	integer seed, errors, checks, timeouts, wait_cnt, cycle, frame_idx;
	integer line_len, pix, row, frame_rows, win_seen, win_ones;
	logic [5:0] held, exp_btn;           // {start_2p, start_1p, coin, fire, right, left}
	logic [8:0] row_m;
	logic par_m, hs_prev, vs_prev, win_active, exp_audio;
	logic [`CAB_DAC_BITS-1:0] acc_m;
	logic [4:0] st_a, st_b;              // {r, g, b, hs, vs} after the colorizer
	logic par_a, par_b;

	tb_clock_gen clock_gen_i (.clk_sys(clk_sys), .rst_n(rst_n));

	cabinet_top dut_i (
		.clk_sys(clk_sys), .rst_n(rst_n), .key_strobe(key_strobe),
		.key_pressed(key_pressed), .key_code(key_code), .joystick_0(joystick_0),
		.joystick_1(joystick_1), .video(video), .hsync(hsync), .vsync(vsync),
		.overlay_off(overlay_off), .scanlines(scanlines), .audio(audio),
		.move_left(move_left), .move_right(move_right), .fire(fire), .coin(coin),
		.start_1p(start_1p), .start_2p(start_2p), .vga_r(vga_r), .vga_g(vga_g),
		.vga_b(vga_b), .vga_hs(vga_hs), .vga_vs(vga_vs), .audio_out(audio_out)
	);

	task automatic compare_signal(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks = checks + 1;
		assert (expected === actual) else begin
			$display("ERROR time %0t: %s expected %0h actual %0h", $time, name,
				expected, actual);
			errors = errors + 1;
		end
	endtask

	// Level of a lit channel for the line parity and the scanline setting
	function automatic logic [5:0] lit_value(input logic odd, input scanline_level_t lvl);
		if (!odd) return 6'd63;
		case (lvl)
			SCAN_25: return 6'd48;
			SCAN_50: return 6'd32;
			SCAN_75: return 6'd16;
			default: return 6'd63;
		endcase
	endfunction

	task automatic check_outputs();
		logic [5:0] lvl;
		lvl = lit_value(par_b, scanlines);
		compare_signal("move_left", exp_btn[0], move_left);
		compare_signal("move_right", exp_btn[1], move_right);
		compare_signal("fire", exp_btn[2], fire);
		compare_signal("coin", exp_btn[3], coin);
		compare_signal("start_1p", exp_btn[4], start_1p);
		compare_signal("start_2p", exp_btn[5], start_2p);
		compare_signal("vga_r", st_b[4] ? lvl : 6'd0, vga_r);
		compare_signal("vga_g", st_b[3] ? lvl : 6'd0, vga_g);
		compare_signal("vga_b", st_b[2] ? lvl : 6'd0, vga_b);
		compare_signal("vga_hs", st_b[1], vga_hs);
		compare_signal("vga_vs", st_b[0], vga_vs);
		compare_signal("audio_out", exp_audio, audio_out);
		if (win_active) begin
			win_ones = win_ones + audio_out;
			win_seen = win_seen + 1;
			if (win_seen == 256) begin
				compare_signal("audio_out ones", audio, win_ones);
				win_active = 1'b0;
			end
		end
	endtask

	task automatic drive_keys();
		integer pick;
		key_strobe = (($unsigned($random(seed)) % 4) == 0);
		key_pressed = $random(seed);
		pick = $unsigned($random(seed)) % 8;
		case (pick)
			0: key_code = KEY_LEFT;
			1: key_code = KEY_RIGHT;
			2: key_code = KEY_FIRE;
			3: key_code = KEY_COIN;
			4: key_code = KEY_START_1P;
			5: key_code = KEY_START_2P;
			default: key_code = $random(seed); // Mostly unknown codes
		endcase
		if (($unsigned($random(seed)) % 8) == 0) joystick_0 = $random(seed);
		if (($unsigned($random(seed)) % 8) == 0) joystick_1 = $random(seed);
		if (key_strobe) begin
			case (key_code)
				8'h6B: held[0] = key_pressed;
				8'h74: held[1] = key_pressed;
				8'h29: held[2] = key_pressed;
				8'h76: held[3] = key_pressed;
				8'h05: held[4] = key_pressed;
				8'h06: held[5] = key_pressed;
				default: ;
			endcase
		end
		exp_btn = held;
		exp_btn[0] = held[0] | joystick_0[1] | joystick_1[1];
		exp_btn[1] = held[1] | joystick_0[0] | joystick_1[0];
		exp_btn[2] = held[2] | joystick_0[4] | joystick_1[4];
	endtask

	task automatic drive_video();
		logic [2:0] band;
		if (pix == line_len) begin
			pix = 0;
			line_len = 4 + $unsigned($random(seed)) % 5;
			row = row + 1;
			if (row == frame_rows) begin
				row = 0;
				frame_rows = 200 + $unsigned($random(seed)) % 21;
				frame_idx = frame_idx + 1;
				scanlines = scanline_level_t'(frame_idx % 4);
				overlay_off = (frame_idx % 4 == 3) ? 1'b1 : 1'b0;
			end
		end
		hsync = (pix == 0);
		vsync = (row == 0);
		video = $random(seed);
		pix = pix + 1;
		if (overlay_off) band = 3'b111;
		else if (row_m < `CAB_SCORE_ROW_END) band = 3'b100;
		else if (row_m >= `CAB_BASE_ROW_START) band = 3'b010;
		else band = 3'b111;
		st_a = {video ? band : 3'b000, hsync, vsync};
		par_a = par_m;
		if (vsync && !vs_prev) begin
			row_m = 0;
			par_m = 1'b0;
		end else if (hsync && !hs_prev) begin
			row_m = row_m + 1;
			par_m = ~par_m;
		end
		hs_prev = hsync;
		vs_prev = vsync;
	endtask

	task automatic drive_audio();
		if (!win_active) begin
			audio = $random(seed);
			win_active = 1'b1;
			win_seen = 0;
			win_ones = 0;
		end
		{exp_audio, acc_m} = {1'b0, acc_m} + {1'b0, audio};
	endtask

	initial begin
		seed = 70449;
		errors = 0;
		checks = 0;
		timeouts = 0;
		key_strobe = 0;
		key_pressed = 0;
		key_code = 0;
		joystick_0 = 0;
		joystick_1 = 0;
		video = 0;
		hsync = 0;
		vsync = 0;
		overlay_off = 0;
		scanlines = SCAN_OFF;
		audio = 0;
		held = 0;
		exp_btn = 0;
		row_m = 0;
		par_m = 0;
		hs_prev = 0;
		vs_prev = 0;
		acc_m = 0;
		exp_audio = 0;
		st_a = 0;
		st_b = 0;
		par_a = 0;
		par_b = 0;
		win_active = 0;
		win_seen = 0;
		win_ones = 0;
		pix = 0;
		row = 0;
		line_len = 6;
		frame_rows = 210;
		frame_idx = 0;
		wait_cnt = 0;
		while (rst_n !== 1'b1 && wait_cnt < 100) begin
			@(posedge clk_sys);
			#1;
			wait_cnt = wait_cnt + 1;
		end
		if (rst_n !== 1'b1) begin
			$display("Timeout: reset was never released");
			timeouts = timeouts + 1;
		end else begin
			check_outputs(); // Reset values before the first edge after the release
			cycle = 0;
			while (frame_idx < 6 && cycle < 20000) begin
				drive_keys();
				drive_video();
				drive_audio();
				@(posedge clk_sys);
				#1;
				check_outputs();
				st_b = st_a;
				par_b = par_a;
				cycle = cycle + 1;
			end
			if (frame_idx < 6) begin
				$display("Timeout: the frame sequence did not finish in time");
				timeouts = timeouts + 1;
			end
		end
		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- cabinet.f
+incdir+.
cab_input_pkg.sv
cab_video_pkg.sv
key_decoder.sv
overlay_colorizer.sv
scanline_dimmer.sv
sigma_delta_dac.sv
cabinet_top.sv
tb_clock_gen.sv
cabinet_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cabinet testbench with Verilator

verilator --binary --timing --assert --top-module cabinet_tb -f cabinet.f \
	-o cabinet_sim > build.log 2>&1 \
	&& ./obj_dir/cabinet_sim > sim.log 2>&1 \
	|| { echo "Build or simulation aborted, see build.log and sim.log"; exit 1; }

grep -q "^TEST PASSED$" sim.log \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
